/* common/sdram_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM router shared definitions
// Widths, client slots and the SDRAM data word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package sdram_pkg;

    // Word address width of one SDRAM bank
    localparam int sdram_aw = 22;

    typedef logic [sdram_aw-1:0] sdram_addr_t;
    typedef logic [15:0]         half_t;

    // Data select, active low, bit 1 is the upper byte
    typedef logic [1:0] byte_mask_t;

    // Graphics reads the whole word
    // CPU and DMA take one 16-bit half, index 0 is the low half
    typedef union packed {
        logic [31:0] full;
        half_t [1:0] halves;
    } sdram_word_t;

    // Client slots on bank 0
    localparam int cl_ram  = 0;
    localparam int cl_vram = 1;

    // Client slots on bank 2
    localparam int cl_gfx0 = 0;
    localparam int cl_gfx1 = 1;

endpackage

`default_nettype wire

/* design/req_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request capture for one memory client
// Detects new requests and maps the address into bank words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module req_capture #(
    parameter sdram_pkg::sdram_addr_t BANK_OFFSET = '0,
    parameter bit                     WIDE        = 1'b0,
    parameter int                     AW          = 17
) (
    input  logic                   VB,
    input  logic                   rst_n,
    input  logic                   cs,
    input  logic [AW-1:0]          addr,
    input  logic                   rnw,
    input  sdram_pkg::half_t       din,
    input  sdram_pkg::byte_mask_t  dsn,
    input  logic                   done,
    output logic                   req,
    output logic                   new_req,
    output sdram_pkg::sdram_addr_t req_addr,
    output logic                   half_sel,
    output logic                   req_wr,
    output sdram_pkg::half_t       req_din,
    output sdram_pkg::byte_mask_t  req_mask
);

    logic                   last_cs;
    logic [AW-1:0]          last_addr;
    logic                   last_rnw;
    sdram_pkg::half_t       last_din;
    sdram_pkg::byte_mask_t  last_dsn;
    logic                   again;
    logic                   changed;
    logic                   start;
    logic                   issue;
    logic [AW-1:0]          src_addr;
    sdram_pkg::sdram_addr_t word_addr;

    // Write data only counts on writes
    assign changed = addr != last_addr || rnw != last_rnw ||
                     (!rnw && (din != last_din || dsn != last_dsn));
    assign start   = cs && (!last_cs || changed);

    // Start now if idle, else replay the newest capture once the bank is done
    assign issue   = (start && (!req || done)) || (done && again);

    // Data is stale when cs dropped or a newer request is queued
    assign new_req = start || (last_cs && !cs) || (done && (again || !cs));

    assign src_addr  = start ? addr : last_addr;
    assign word_addr = (WIDE ? sdram_pkg::sdram_addr_t'(src_addr)
                             : sdram_pkg::sdram_addr_t'(src_addr >> 1)) + BANK_OFFSET;

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            last_cs <= 1'b0;
            req     <= 1'b0;
            again   <= 1'b0;
        end else begin
            last_cs <= cs;
            if (issue) begin
                req <= 1'b1;
            end else if (done) begin
                req <= 1'b0;
            end
            if (start && req && !done) begin
                again <= 1'b1;
            end else if (done) begin
                again <= 1'b0;
            end
        end
    end

    always_ff @(posedge VB) begin
        if (start) begin
            last_addr <= addr;
            last_rnw  <= rnw;
            last_din  <= din;
            last_dsn  <= dsn;
        end
        // Held stable while the bank works on it
        if (issue) begin
            req_addr <= word_addr;
            half_sel <= WIDE ? 1'b0 : src_addr[0];
            req_wr   <= start ? !rnw : !last_rnw;
            req_din  <= start ? din : last_din;
            req_mask <= start ? dsn : last_dsn;
        end
    end

endmodule

`default_nettype wire

/* bank_arbiter/bank_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter for one SDRAM bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter #(
    parameter int N        = 2,
    parameter bit WRITABLE = 1'b0
) (
    input  logic                               VB,
    input  logic                               rst_n,
    input  logic [N-1:0]                       req,
    input  sdram_pkg::sdram_addr_t [N-1:0]     req_addr,
    input  logic [N-1:0]                       req_wr,
    input  sdram_pkg::half_t [N-1:0]           req_din,
    input  sdram_pkg::byte_mask_t [N-1:0]      req_mask,
    input  logic                               ack,
    input  logic                               rdy,
    output logic [N-1:0]                       done,
    output sdram_pkg::sdram_addr_t             addr,
    output logic                               rd,
    output logic                               wr,
    output sdram_pkg::half_t                   din,
    output sdram_pkg::byte_mask_t              din_m
);

    localparam int IW = N > 1 ? $clog2(N) : 1;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ACK  = 2'd1;
    localparam logic [1:0] ST_RDY  = 2'd2;

    logic [1:0]    state;
    // Last granted client, also the owner of the access in flight
    logic [IW-1:0] owner;
    logic [IW-1:0] pick;
    logic          found;

    // Search starts just after the last winner
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = owner;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(owner) + k) % N;
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = IW'(idx);
            end
        end
    end

    // Data is valid on the rdy edge, so done is not registered
    always_comb begin
        done = '0;
        if (state == ST_RDY && rdy) begin
            done[owner] = 1'b1;
        end
    end

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            owner <= '0;
            rd    <= 1'b0;
            wr    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (found) begin
                        owner <= pick;
                        rd    <= !(WRITABLE && req_wr[pick]);
                        wr    <= WRITABLE && req_wr[pick];
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (ack) begin
                        rd    <= 1'b0;
                        wr    <= 1'b0;
                        state <= ST_RDY;
                    end
                end
                ST_RDY: begin
                    if (rdy) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address and write data frozen at grant
    always_ff @(posedge VB) begin
        if (state == ST_IDLE && found) begin
            addr  <= req_addr[pick];
            din   <= req_din[pick];
            din_m <= req_mask[pick];
        end
    end

endmodule

`default_nettype wire

/* design/rd_steer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read data latch and ok flag per client
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rd_steer #(
    parameter bit WIDE = 1'b0
) (
    input  logic                   VB,
    input  logic                   rst_n,
    input  logic                   new_req,
    input  logic                   done,
    input  logic                   half_sel,
    input  sdram_pkg::sdram_word_t data_read,
    output sdram_pkg::sdram_word_t data,
    output logic                   ok
);

    always_ff @(posedge VB) begin
        if (done) begin
            if (WIDE) begin
                data.full <= data_read.full;
            end else begin
                // Narrow clients see their half in the low bits
                data.halves[1] <= '0;
                data.halves[0] <= data_read.halves[half_sel];
            end
        end
    end

    // A new or dropped request wins over a late done
    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            ok <= 1'b0;
        end else if (new_req) begin
            ok <= 1'b0;
        end else if (done) begin
            ok <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/sdram_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM router top level
// Connects five memory clients to three SDRAM banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sdram_router #(
    parameter sdram_pkg::sdram_addr_t RAM_OFFSET  = 22'h00_0000,
    parameter sdram_pkg::sdram_addr_t VRAM_OFFSET = 22'h01_0000,
    parameter sdram_pkg::sdram_addr_t ROM_OFFSET  = 22'h00_0000,
    parameter sdram_pkg::sdram_addr_t GFX_OFFSET  = 22'h00_0000
) (
    input  logic                   VB,
    input  logic                   rst_n,
    // Main CPU ROM
    input  logic                   main_rom_cs,
    input  logic [20:0]            main_rom_addr,
    output logic                   main_rom_ok,
    output sdram_pkg::half_t       main_rom_data,
    // Main CPU work RAM
    input  logic                   main_ram_cs,
    input  logic [16:0]            main_ram_addr,
    input  logic                   main_ram_rnw,
    input  sdram_pkg::half_t       main_ram_din,
    input  sdram_pkg::byte_mask_t  main_ram_dsn,
    output logic                   main_ram_ok,
    output sdram_pkg::half_t       main_ram_data,
    // Video RAM DMA
    input  logic                   vram_dma_cs,
    input  logic [16:0]            vram_dma_addr,
    output logic                   vram_dma_ok,
    output sdram_pkg::half_t       vram_dma_data,
    // Graphics ROM channels
    input  logic                   rom0_cs,
    input  logic [19:0]            rom0_addr,
    output logic                   rom0_ok,
    output sdram_pkg::sdram_word_t rom0_data,
    input  logic                   rom1_cs,
    input  logic [19:0]            rom1_addr,
    output logic                   rom1_ok,
    output sdram_pkg::sdram_word_t rom1_data,
    // Bank 0, read and write
    output sdram_pkg::sdram_addr_t ba0_addr,
    output logic                   ba0_rd,
    output logic                   ba0_wr,
    output sdram_pkg::half_t       ba0_din,
    output sdram_pkg::byte_mask_t  ba0_din_m,
    input  logic                   ba0_ack,
    input  logic                   ba0_rdy,
    // Bank 1, main ROM
    output sdram_pkg::sdram_addr_t ba1_addr,
    output logic                   ba1_rd,
    input  logic                   ba1_ack,
    input  logic                   ba1_rdy,
    // Bank 2, graphics
    output sdram_pkg::sdram_addr_t ba2_addr,
    output logic                   ba2_rd,
    input  logic                   ba2_ack,
    input  logic                   ba2_rdy,
    input  sdram_pkg::sdram_word_t data_read
);

    // Request buses, one slot per client of each bank
    logic [1:0]                         b0_req, b0_wr, b0_done;
    sdram_pkg::sdram_addr_t [1:0]       b0_addr;
    sdram_pkg::half_t [1:0]             b0_din;
    sdram_pkg::byte_mask_t [1:0]        b0_mask;
    logic [0:0]                         b1_req, b1_wr, b1_done;
    sdram_pkg::sdram_addr_t [0:0]       b1_addr;
    sdram_pkg::half_t [0:0]             b1_din;
    sdram_pkg::byte_mask_t [0:0]        b1_mask;
    logic [1:0]                         b2_req, b2_wr, b2_done;
    sdram_pkg::sdram_addr_t [1:0]       b2_addr;
    sdram_pkg::half_t [1:0]             b2_din;
    sdram_pkg::byte_mask_t [1:0]        b2_mask;

    logic ram_new, vram_new, rom_new, gfx0_new, gfx1_new;
    logic ram_half, vram_half, rom_half, gfx0_half, gfx1_half;
    sdram_pkg::sdram_word_t ram_word, vram_word, rom_word;

    assign main_ram_data = ram_word.halves[0];
    assign vram_dma_data = vram_word.halves[0];
    assign main_rom_data = rom_word.halves[0];

    // Request capture
    req_capture #(.BANK_OFFSET(RAM_OFFSET), .WIDE(1'b0), .AW(17)) u_ram_cap (
        .VB, .rst_n,
        .cs(main_ram_cs), .addr(main_ram_addr), .rnw(main_ram_rnw),
        .din(main_ram_din), .dsn(main_ram_dsn), .done(b0_done[sdram_pkg::cl_ram]),
        .req(b0_req[sdram_pkg::cl_ram]), .new_req(ram_new), .half_sel(ram_half),
        .req_addr(b0_addr[sdram_pkg::cl_ram]), .req_wr(b0_wr[sdram_pkg::cl_ram]),
        .req_din(b0_din[sdram_pkg::cl_ram]), .req_mask(b0_mask[sdram_pkg::cl_ram])
    );

    // DMA only reads
    req_capture #(.BANK_OFFSET(VRAM_OFFSET), .WIDE(1'b0), .AW(17)) u_vram_cap (
        .VB, .rst_n,
        .cs(vram_dma_cs), .addr(vram_dma_addr), .rnw(1'b1),
        .din('0), .dsn('1), .done(b0_done[sdram_pkg::cl_vram]),
        .req(b0_req[sdram_pkg::cl_vram]), .new_req(vram_new), .half_sel(vram_half),
        .req_addr(b0_addr[sdram_pkg::cl_vram]), .req_wr(b0_wr[sdram_pkg::cl_vram]),
        .req_din(b0_din[sdram_pkg::cl_vram]), .req_mask(b0_mask[sdram_pkg::cl_vram])
    );

    req_capture #(.BANK_OFFSET(ROM_OFFSET), .WIDE(1'b0), .AW(21)) u_rom_cap (
        .VB, .rst_n,
        .cs(main_rom_cs), .addr(main_rom_addr), .rnw(1'b1),
        .din('0), .dsn('1), .done(b1_done[0]),
        .req(b1_req[0]), .new_req(rom_new), .half_sel(rom_half),
        .req_addr(b1_addr[0]), .req_wr(b1_wr[0]),
        .req_din(b1_din[0]), .req_mask(b1_mask[0])
    );

    req_capture #(.BANK_OFFSET(GFX_OFFSET), .WIDE(1'b1), .AW(20)) u_gfx0_cap (
        .VB, .rst_n,
        .cs(rom0_cs), .addr(rom0_addr), .rnw(1'b1),
        .din('0), .dsn('1), .done(b2_done[sdram_pkg::cl_gfx0]),
        .req(b2_req[sdram_pkg::cl_gfx0]), .new_req(gfx0_new), .half_sel(gfx0_half),
        .req_addr(b2_addr[sdram_pkg::cl_gfx0]), .req_wr(b2_wr[sdram_pkg::cl_gfx0]),
        .req_din(b2_din[sdram_pkg::cl_gfx0]), .req_mask(b2_mask[sdram_pkg::cl_gfx0])
    );

    req_capture #(.BANK_OFFSET(GFX_OFFSET), .WIDE(1'b1), .AW(20)) u_gfx1_cap (
        .VB, .rst_n,
        .cs(rom1_cs), .addr(rom1_addr), .rnw(1'b1),
        .din('0), .dsn('1), .done(b2_done[sdram_pkg::cl_gfx1]),
        .req(b2_req[sdram_pkg::cl_gfx1]), .new_req(gfx1_new), .half_sel(gfx1_half),
        .req_addr(b2_addr[sdram_pkg::cl_gfx1]), .req_wr(b2_wr[sdram_pkg::cl_gfx1]),
        .req_din(b2_din[sdram_pkg::cl_gfx1]), .req_mask(b2_mask[sdram_pkg::cl_gfx1])
    );

    // Bank arbitration
    bank_arbiter #(.N(2), .WRITABLE(1'b1)) u_ba0_arb (
        .VB, .rst_n,
        .req(b0_req), .req_addr(b0_addr), .req_wr(b0_wr),
        .req_din(b0_din), .req_mask(b0_mask), .ack(ba0_ack), .rdy(ba0_rdy),
        .done(b0_done), .addr(ba0_addr), .rd(ba0_rd), .wr(ba0_wr),
        .din(ba0_din), .din_m(ba0_din_m)
    );

    bank_arbiter #(.N(1), .WRITABLE(1'b0)) u_ba1_arb (
        .VB, .rst_n,
        .req(b1_req), .req_addr(b1_addr), .req_wr(b1_wr),
        .req_din(b1_din), .req_mask(b1_mask), .ack(ba1_ack), .rdy(ba1_rdy),
        .done(b1_done), .addr(ba1_addr), .rd(ba1_rd), .wr(),
        .din(), .din_m()
    );

    bank_arbiter #(.N(2), .WRITABLE(1'b0)) u_ba2_arb (
        .VB, .rst_n,
        .req(b2_req), .req_addr(b2_addr), .req_wr(b2_wr),
        .req_din(b2_din), .req_mask(b2_mask), .ack(ba2_ack), .rdy(ba2_rdy),
        .done(b2_done), .addr(ba2_addr), .rd(ba2_rd), .wr(),
        .din(), .din_m()
    );

    // Read data steering
    rd_steer #(.WIDE(1'b0)) u_ram_steer (
        .VB, .rst_n, .new_req(ram_new), .done(b0_done[sdram_pkg::cl_ram]),
        .half_sel(ram_half), .data_read, .data(ram_word), .ok(main_ram_ok)
    );

    rd_steer #(.WIDE(1'b0)) u_vram_steer (
        .VB, .rst_n, .new_req(vram_new), .done(b0_done[sdram_pkg::cl_vram]),
        .half_sel(vram_half), .data_read, .data(vram_word), .ok(vram_dma_ok)
    );

    rd_steer #(.WIDE(1'b0)) u_rom_steer (
        .VB, .rst_n, .new_req(rom_new), .done(b1_done[0]),
        .half_sel(rom_half), .data_read, .data(rom_word), .ok(main_rom_ok)
    );

    rd_steer #(.WIDE(1'b1)) u_gfx0_steer (
        .VB, .rst_n, .new_req(gfx0_new), .done(b2_done[sdram_pkg::cl_gfx0]),
        .half_sel(gfx0_half), .data_read, .data(rom0_data), .ok(rom0_ok)
    );

    rd_steer #(.WIDE(1'b1)) u_gfx1_steer (
        .VB, .rst_n, .new_req(gfx1_new), .done(b2_done[sdram_pkg::cl_gfx1]),
        .half_sel(gfx1_half), .data_read, .data(rom1_data), .ok(rom1_ok)
    );

endmodule

`default_nettype wire

/* verif/sdram_bank_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral SDRAM bank with random ack and rdy delays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sdram_bank_model #(
    parameter int          BANK = 0,
    parameter logic [31:0] SEED = 32'd54036
) (
    input  logic                   VB,
    input  logic                   rst_n,
    input  sdram_pkg::sdram_addr_t addr,
    input  logic                   rd,
    input  logic                   wr,
    input  sdram_pkg::half_t       din,
    input  sdram_pkg::byte_mask_t  din_m,
    input  logic                   slot,
    output logic                   ack,
    output logic                   rdy,
    output sdram_pkg::sdram_word_t dout,
    output logic                   err
);

    typedef enum logic [2:0] {S_IDLE, S_ACKW, S_ACKD, S_RDYW, S_DONE} state_t;

    state_t                 state;
    logic [31:0]            rng;
    logic [2:0]             cnt;
    sdram_pkg::sdram_addr_t a_q;
    logic                   wr_q;
    logic [31:0]            mem [sdram_pkg::sdram_addr_t];

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Unwritten words, a fixed function of bank and address
    function automatic logic [31:0] fill_word(input sdram_pkg::sdram_addr_t a);
        return (32'(a) * 32'h9E37_79B1) ^ (32'(BANK) << 28) ^ 32'h05A5_C3E1;
    endfunction

    function automatic logic [15:0] merge16(input logic [15:0] old, input logic [15:0] d,
                                            input logic [1:0] m);
        return {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
    endfunction

    always @(posedge VB or negedge rst_n) begin
        logic [31:0] w;
        if (!rst_n) begin
            state <= S_IDLE;
            rng   <= SEED;
            cnt   <= '0;
            ack   <= 1'b0;
            rdy   <= 1'b0;
            err   <= 1'b0;
            dout  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (rd || wr) begin
                        a_q   <= addr;
                        wr_q  <= wr;
                        rng   <= xorshift32(rng);
                        cnt   <= 3'(xorshift32(rng) % 6);
                        state <= S_ACKW;
                    end
                end
                S_ACKW, S_ACKD: begin
                    // Request must hold still until ack is seen
                    if (addr != a_q || wr != wr_q || rd == wr_q || !(rd || wr)) begin
                        err <= 1'b1;
                    end
                    if (state == S_ACKD) begin
                        ack   <= 1'b0;
                        rng   <= xorshift32(rng);
                        cnt   <= 3'(xorshift32(rng) % 6);
                        state <= S_RDYW;
                    end else if (cnt == 0) begin
                        ack   <= 1'b1;
                        state <= S_ACKD;
                        if (wr_q) begin
                            w = mem.exists(a_q) ? mem[a_q] : fill_word(a_q);
                            // Both halves take the masked write
                            mem[a_q] = {merge16(w[31:16], din, din_m),
                                        merge16(w[15:0], din, din_m)};
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_RDYW: begin
                    // A second access before rdy
                    if (rd || wr) begin
                        err <= 1'b1;
                    end
                    if (cnt != 0) begin
                        cnt <= cnt - 1'b1;
                    end else if (slot) begin
                        rdy   <= 1'b1;
                        dout  <= mem.exists(a_q) ? mem[a_q] : fill_word(a_q);
                        state <= S_DONE;
                    end
                end
                default: begin
                    rdy   <= 1'b0;
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verif/sdram_router_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM router testbench with random traffic and a shadow model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sdram_router_tb;

    localparam int ROUNDS  = 40;
    localparam int WRITES  = 20;
    localparam int NTRANS  = 5 + 5 * ROUNDS + 2 * WRITES + 2;
    // Worst case cycles per access with two clients on one bank
    localparam int BOUND   = 60;
    localparam int TIMEOUT = NTRANS * BOUND * 8 + 500;

    logic VB;
    logic rst_n;
    logic main_rom_cs, main_ram_cs, main_ram_rnw, vram_dma_cs, rom0_cs, rom1_cs;
    logic [20:0] main_rom_addr;
    logic [16:0] main_ram_addr, vram_dma_addr;
    logic [19:0] rom0_addr, rom1_addr;
    sdram_pkg::half_t main_ram_din;
    sdram_pkg::byte_mask_t main_ram_dsn;
    logic main_rom_ok, main_ram_ok, vram_dma_ok, rom0_ok, rom1_ok;
    sdram_pkg::half_t main_rom_data, main_ram_data, vram_dma_data;
    sdram_pkg::sdram_word_t rom0_data, rom1_data, data_read;
    sdram_pkg::sdram_addr_t ba0_addr, ba1_addr, ba2_addr;
    logic ba0_rd, ba0_wr, ba1_rd, ba2_rd;
    sdram_pkg::half_t ba0_din;
    sdram_pkg::byte_mask_t ba0_din_m;
    logic [2:0] ack, rdy, err;
    sdram_pkg::sdram_word_t dout [3];
    int unsigned cyc;
    logic [31:0] rng;
    logic [31:0] shadow [sdram_pkg::sdram_addr_t];
    string names [5] = '{"main_ram_data", "vram_dma_data", "main_rom_data",
                         "rom0_data", "rom1_data"};
    string ok_names [5] = '{"main_ram_ok", "vram_dma_ok", "main_rom_ok",
                            "rom0_ok", "rom1_ok"};

    sdram_router sdram_router_i (
        .VB, .rst_n,
        .main_rom_cs, .main_rom_addr, .main_rom_ok, .main_rom_data,
        .main_ram_cs, .main_ram_addr, .main_ram_rnw, .main_ram_din, .main_ram_dsn,
        .main_ram_ok, .main_ram_data,
        .vram_dma_cs, .vram_dma_addr, .vram_dma_ok, .vram_dma_data,
        .rom0_cs, .rom0_addr, .rom0_ok, .rom0_data,
        .rom1_cs, .rom1_addr, .rom1_ok, .rom1_data,
        .ba0_addr, .ba0_rd, .ba0_wr, .ba0_din, .ba0_din_m, .ba0_ack(ack[0]), .ba0_rdy(rdy[0]),
        .ba1_addr, .ba1_rd, .ba1_ack(ack[1]), .ba1_rdy(rdy[1]),
        .ba2_addr, .ba2_rd, .ba2_ack(ack[2]), .ba2_rdy(rdy[2]),
        .data_read
    );

    // Banks take turns for rdy because data_read is shared
    sdram_bank_model #(.BANK(0), .SEED(32'd54036)) bank0_i (
        .VB, .rst_n, .addr(ba0_addr), .rd(ba0_rd), .wr(ba0_wr), .din(ba0_din),
        .din_m(ba0_din_m), .slot(cyc % 3 == 0), .ack(ack[0]), .rdy(rdy[0]),
        .dout(dout[0]), .err(err[0])
    );

    sdram_bank_model #(.BANK(1), .SEED(32'd54037)) bank1_i (
        .VB, .rst_n, .addr(ba1_addr), .rd(ba1_rd), .wr(1'b0), .din('0),
        .din_m(2'b11), .slot(cyc % 3 == 1), .ack(ack[1]), .rdy(rdy[1]),
        .dout(dout[1]), .err(err[1])
    );

    sdram_bank_model #(.BANK(2), .SEED(32'd54038)) bank2_i (
        .VB, .rst_n, .addr(ba2_addr), .rd(ba2_rd), .wr(1'b0), .din('0),
        .din_m(2'b11), .slot(cyc % 3 == 2), .ack(ack[2]), .rdy(rdy[2]),
        .dout(dout[2]), .err(err[2])
    );

    assign data_read = rdy[0] ? dout[0] : (rdy[1] ? dout[1] : dout[2]);

    initial begin
        VB = 1'b0;
        forever #4 VB = ~VB;
    end

    always @(posedge VB) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] expect_word(input int bank, input sdram_pkg::sdram_addr_t wa);
        if (bank == 0 && shadow.exists(wa)) begin
            return shadow[wa];
        end
        return (32'(wa) * 32'h9E37_79B1) ^ (32'(bank) << 28) ^ 32'h05A5_C3E1;
    endfunction

    function automatic logic [15:0] merge16(input logic [15:0] old, input logic [15:0] d,
                                            input logic [1:0] m);
        return {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
    endfunction

    task automatic fail_now();
        $display("Test FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_half(input string name, input sdram_pkg::half_t got,
                              input sdram_pkg::half_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_word(input string name, input sdram_pkg::sdram_word_t got,
                              input sdram_pkg::sdram_word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            fail_now();
        end
    endtask

    // Client order is main RAM, VRAM DMA, main ROM, then the two graphics channels
    task automatic drive(input int cl, input logic cs, input logic [20:0] a, input logic rnw,
                         input sdram_pkg::half_t d, input sdram_pkg::byte_mask_t m);
        case (cl)
            0: begin
                main_ram_cs   = cs;
                main_ram_addr = a[16:0];
                main_ram_rnw  = rnw;
                main_ram_din  = d;
                main_ram_dsn  = m;
            end
            1: begin
                vram_dma_cs   = cs;
                vram_dma_addr = a[16:0];
            end
            2: begin
                main_rom_cs   = cs;
                main_rom_addr = a;
            end
            3: begin
                rom0_cs   = cs;
                rom0_addr = a[19:0];
            end
            default: begin
                rom1_cs   = cs;
                rom1_addr = a[19:0];
            end
        endcase
    endtask

    function automatic logic get_ok(input int cl);
        logic [4:0] oks;
        oks = {rom1_ok, rom0_ok, main_rom_ok, vram_dma_ok, main_ram_ok};
        return oks[cl];
    endfunction

    function automatic sdram_pkg::half_t get_half(input int cl);
        return cl == 0 ? main_ram_data : (cl == 1 ? vram_dma_data : main_rom_data);
    endfunction

    function automatic int bank_of(input int cl);
        return cl < 2 ? 0 : (cl == 2 ? 1 : 2);
    endfunction

    function automatic sdram_pkg::sdram_addr_t word_addr(input int cl, input logic [20:0] a);
        case (cl)
            0: return sdram_pkg::sdram_addr_t'(a[16:1]);
            1: return sdram_pkg::sdram_addr_t'(a[16:1]) + 22'h01_0000;
            2: return sdram_pkg::sdram_addr_t'(a[20:1]);
            default: return sdram_pkg::sdram_addr_t'(a[19:0]);
        endcase
    endfunction

    task automatic wait_ok(input int cl);
        // ok must be low in the cycle after the start edge
        @(posedge VB);
        @(negedge VB);
        check_bit(ok_names[cl], get_ok(cl), 1'b0);
        while (!get_ok(cl)) begin
            @(negedge VB);
        end
    endtask

    task automatic check_data(input int cl, input logic [20:0] a);
        sdram_pkg::sdram_word_t w;
        w = expect_word(bank_of(cl), word_addr(cl, a));
        if (cl < 3) begin
            check_half(names[cl], get_half(cl), w.halves[a[0]]);
        end else begin
            check_word(names[cl], cl == 3 ? rom0_data : rom1_data, w);
        end
    endtask

    task automatic access(input int cl, input logic [20:0] a, input logic rnw,
                          input sdram_pkg::half_t d, input sdram_pkg::byte_mask_t m);
        sdram_pkg::sdram_addr_t wa;
        logic [31:0] w;
        wa = word_addr(cl, a);
        @(posedge VB);
        #1;
        drive(cl, 1'b1, a, rnw, d, m);
        wait_ok(cl);
        if (rnw) begin
            check_data(cl, a);
        end else begin
            w = expect_word(0, wa);
            shadow[wa] = {merge16(w[31:16], d, m), merge16(w[15:0], d, m)};
        end
        @(posedge VB);
        #1;
        drive(cl, 1'b0, a, 1'b1, d, 2'b11);
    endtask

    // Address moves under a held cs
    task automatic addr_change(input logic [19:0] a, input logic [19:0] b);
        @(posedge VB);
        #1;
        drive(3, 1'b1, 21'(a), 1'b1, '0, 2'b11);
        wait_ok(3);
        check_data(3, 21'(a));
        @(posedge VB);
        #1;
        drive(3, 1'b1, 21'(b), 1'b1, '0, 2'b11);
        wait_ok(3);
        check_data(3, 21'(b));
        @(posedge VB);
        #1;
        drive(3, 1'b0, 21'(b), 1'b1, '0, 2'b11);
    endtask

    always @(negedge VB) begin
        if (|err) begin
            $display("Bank protocol violated: request changed before ack or overlapped");
            fail_now();
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the DUT did not finish its accesses in time");
        fail_now();
    end

    initial begin
        logic [20:0] ad [5];
        logic rw;
        logic [15:0] d;
        logic [1:0] m;
        rng = 32'd54036;
        cyc = 0;
        rst_n = 1'b0;
        for (int c = 0; c < 5; c++) begin
            drive(c, 1'b0, '0, 1'b1, '0, 2'b11);
        end
        repeat (2) @(posedge VB);
        #1;
        rst_n = 1'b1;

        // Quiet outputs before any cs
        repeat (4) begin
            @(negedge VB);
            check_bit("ba0_rd", ba0_rd, 1'b0);
            check_bit("ba0_wr", ba0_wr, 1'b0);
            check_bit("ba1_rd", ba1_rd, 1'b0);
            check_bit("ba2_rd", ba2_rd, 1'b0);
            for (int c = 0; c < 5; c++) begin
                check_bit(ok_names[c], get_ok(c), 1'b0);
            end
        end

        for (int c = 0; c < 5; c++) begin
            access(c, 21'(next_rand()), 1'b1, '0, 2'b11);
        end

        for (int r = 0; r < ROUNDS; r++) begin
            for (int c = 0; c < 5; c++) begin
                ad[c] = 21'(next_rand());
            end
            rw = next_rand() % 4 != 0;
            d = 16'(next_rand());
            m = 2'(next_rand());
            fork
                access(0, ad[0], rw, d, m);
                access(1, ad[1], 1'b1, '0, 2'b11);
                access(2, ad[2], 1'b1, '0, 2'b11);
                access(3, ad[3], 1'b1, '0, 2'b11);
                access(4, ad[4], 1'b1, '0, 2'b11);
            join
        end

        for (int k = 0; k < WRITES; k++) begin
            ad[0] = 21'(next_rand());
            d = 16'(next_rand());
            m = 2'(next_rand());
            access(0, ad[0], 1'b0, d, m);
            access(0, ad[0], 1'b1, '0, 2'b11);
        end

        addr_change(20'(next_rand()), 20'(next_rand()));

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
common/sdram_pkg.sv
design/req_capture.sv
bank_arbiter/bank_arbiter.sv
design/rd_steer.sv
design/sdram_router.sv
verif/sdram_bank_model.sv
verif/sdram_router_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = sdram_router_tb
FILELIST = compile.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
